// File: Bender.yml
package:
  name: exec_stage

sources:
  - hw/exec_pkg.sv
  - hw/exec_alu.sv
  - hw/exec_branch.sv
  - hw/exec_lsu.sv
  - hw/exec_csr.sv
  - hw/exec_redirect.sv
  - hw/exec_stage.sv
  - target: test
    files:
      - tb/exec_assert.sv
      - tb/exec_tb.sv

// File: build.f
hw/exec_pkg.sv
hw/exec_alu.sv
hw/exec_branch.sv
hw/exec_lsu.sv
hw/exec_csr.sv
hw/exec_redirect.sv
hw/exec_stage.sv
tb/exec_assert.sv
tb/exec_tb.sv

// File: hw/exec_alu.sv
// Integer ALU: two adders, bitwise and shift units, comparison flags
module exec_alu (
    input  exec_pkg::op_e        op_i,
    input  exec_pkg::word_t      pc_i,
    input  exec_pkg::word_t      first_i,
    input  exec_pkg::word_t      second_i,
    input  exec_pkg::word_t      third_i,
    output exec_pkg::word_t      sum_o,
    output exec_pkg::word_t      link_sum_o,
    output exec_pkg::word_t      and_o,
    output exec_pkg::word_t      or_o,
    output exec_pkg::word_t      xor_o,
    output exec_pkg::word_t      sll_o,
    output exec_pkg::word_t      srl_o,
    output exec_pkg::word_t      sra_o,
    output exec_pkg::cmp_flags_t flags_o
);
    import exec_pkg::*;

    word_t  link_a;
    word_t  link_b;
    shamt_t shamt;

    ////////////////////
    // Adders
    ////////////////////

    // Second adder serves link address, SUB and branch target
    always_comb begin
        unique case (op_i)
            SUB:     link_a = first_i;
            default: link_a = pc_i;
        endcase
    end

    always_comb begin
        unique case (op_i)
            JAL, JALR: link_b = word_t'(4);
            SUB:       link_b = ~second_i + word_t'(1);
            default:   link_b = third_i;
        endcase
    end

    assign sum_o      = first_i + second_i;
    assign link_sum_o = link_a + link_b;

    ////////////////////
    // Logic and shifts
    ////////////////////

    assign shamt = second_i[4:0];

    assign and_o = first_i & second_i;
    assign or_o  = first_i | second_i;
    assign xor_o = first_i ^ second_i;
    assign sll_o = first_i << shamt;
    assign srl_o = first_i >> shamt;
    assign sra_o = $signed(first_i) >>> shamt;

    // Signed and unsigned comparators
    assign flags_o.equal              = (first_i == second_i);
    assign flags_o.less_than          = ($signed(first_i) < $signed(second_i));
    assign flags_o.less_than_unsigned = (first_i < second_i);

endmodule

// File: hw/exec_branch.sv
// Branch and jump decision with target address selection
module exec_branch (
    input  exec_pkg::op_e        op_i,
    input  exec_pkg::cmp_flags_t flags_i,
    input  exec_pkg::word_t      sum_i,
    input  exec_pkg::word_t      link_sum_i,
    output logic                 taken_o,
    output exec_pkg::word_t      target_o
);
    import exec_pkg::*;

    // Raw decision, kill masking happens in the redirect unit
    always_comb begin
        unique case (op_i)
            BEQ:       taken_o = flags_i.equal;
            BNE:       taken_o = ~flags_i.equal;
            BLT:       taken_o = flags_i.less_than;
            BLTU:      taken_o = flags_i.less_than_unsigned;
            BGE:       taken_o = ~flags_i.less_than;
            BGEU:      taken_o = ~flags_i.less_than_unsigned;
            JAL, JALR: taken_o = 1'b1;
            default:   taken_o = 1'b0;
        endcase
    end

    // JALR drops bit 0, branches use pc plus offset
    always_comb begin
        unique case (op_i)
            JALR:    target_o = {sum_i[XLEN-1:1], 1'b0};
            JAL:     target_o = sum_i;
            default: target_o = link_sum_i;
        endcase
    end

endmodule

// File: hw/exec_csr.sv
// CSR request: enables, operation, write data and illegal access check
module exec_csr (
    input  exec_pkg::op_e      op_i,
    input  exec_pkg::word_t    instruction_i,
    input  exec_pkg::word_t    first_i,
    input  exec_pkg::priv_e    priv_i,
    output exec_pkg::csr_req_t csr_o,
    output logic               illegal_o
);
    import exec_pkg::*;

    logic [4:0] rd;
    logic [4:0] rs1;
    csr_addr_t  address;
    logic       read_req;
    logic       write_req;

    assign rd      = instruction_i[11:7];
    assign rs1     = instruction_i[19:15];
    assign address = instruction_i[31:20];

    // Write forms skip the read for rd = x0, set/clear skip the write for rs1 = x0
    always_comb begin
        unique case (op_i)
            CSRRW, CSRRWI: begin
                read_req  = (rd != '0);
                write_req = 1'b1;
            end
            CSRRS, CSRRC, CSRRSI, CSRRCI: begin
                read_req  = 1'b1;
                write_req = (rs1 != '0);
            end
            default: begin
                read_req  = 1'b0;
                write_req = 1'b0;
            end
        endcase
    end

    // Read-only space is 0b11 in the top bits, bits 9:8 give the minimum level
    assign illegal_o = (write_req && address[11:10] == 2'b11)
                     || ((read_req || write_req) && address[9:8] > priv_i);

    assign csr_o.address      = address;
    assign csr_o.read_enable  = read_req & ~illegal_o;
    assign csr_o.write_enable = write_req & ~illegal_o;

    always_comb begin
        unique case (op_i)
            CSRRW, CSRRWI: csr_o.op = WRITE;
            CSRRS, CSRRSI: csr_o.op = SET;
            CSRRC, CSRRCI: csr_o.op = CLEAR;
            default:       csr_o.op = NONE;
        endcase
    end

    // Immediate forms carry the zero-extended rs1 field
    assign csr_o.data = (op_i inside {CSRRW, CSRRS, CSRRC}) ? first_i : {27'b0, rs1};

endmodule

// File: hw/exec_lsu.sv
// Load/store request: aligned address, read enable, byte strobes, write data
module exec_lsu (
    input  exec_pkg::op_e      op_i,
    input  exec_pkg::word_t    sum_i,
    input  exec_pkg::word_t    store_data_i,
    output exec_pkg::mem_req_t mem_o
);
    import exec_pkg::*;

    logic [1:0] offset;

    assign offset = sum_i[1:0];

    // Word aligned, the byte lane goes into the strobes
    assign mem_o.address     = {sum_i[XLEN-1:2], 2'b00};
    assign mem_o.read_enable = op_i inside {LB, LBU, LH, LHU, LW};

    always_comb begin
        unique case (op_i)
            SB: begin
                unique case (offset)
                    2'b00: mem_o.strobe = strobe_t'(4'b0001);
                    2'b01: mem_o.strobe = strobe_t'(4'b0010);
                    2'b10: mem_o.strobe = strobe_t'(4'b0100);
                    default: mem_o.strobe = strobe_t'(4'b1000);
                endcase
            end
            SH:      mem_o.strobe = offset[1] ? strobe_t'(4'b1100) : strobe_t'(4'b0011);
            SW:      mem_o.strobe = strobe_t'(4'b1111);
            default: mem_o.strobe = strobe_t'(4'b0000);
        endcase
    end

    // Replicate narrow stores across every lane
    always_comb begin
        unique case (op_i)
            SB:      mem_o.write_data = {4{store_data_i[7:0]}};
            SH:      mem_o.write_data = {2{store_data_i[15:0]}};
            default: mem_o.write_data = store_data_i;
        endcase
    end

endmodule

// File: hw/exec_pkg.sv
// Execute stage package: widths, operation and code enums, shared request structs
package exec_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [3:0]      strobe_t;
    typedef logic [4:0]      shamt_t;

    // Decoded operation, one value per instruction class
    typedef enum logic [5:0] {
        ADD, SUB, AND, OR, XOR,
        SLL, SRL, SRA, SLT, SLTU, LUI,
        BEQ, BNE, BLT, BLTU, BGE, BGEU,
        JAL, JALR,
        LB, LBU, LH, LHU, LW,
        SB, SH, SW,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        ECALL, EBREAK, MRET,
        NOP
    } op_e;

    typedef enum logic [1:0] {
        NONE,
        WRITE,
        SET,
        CLEAR
    } csr_op_e;

    typedef enum logic [1:0] {
        USER       = 2'd0,
        SUPERVISOR = 2'd1,
        MACHINE    = 2'd3
    } priv_e;

    // Machine cause codes, NO_EXC marks an idle trap port
    typedef enum logic [3:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 4'd0,
        ILLEGAL_INSTRUCTION            = 4'd2,
        BREAKPOINT                     = 4'd3,
        ECALL_FROM_MMODE               = 4'd11,
        NO_EXC                         = 4'd15
    } exc_code_e;

    // Comparator outputs, greater-or-equal is the inverse of less-than
    typedef struct packed {
        logic equal;
        logic less_than;
        logic less_than_unsigned;
    } cmp_flags_t;

    typedef struct packed {
        word_t   address;
        logic    read_enable;
        strobe_t strobe;
        word_t   write_data;
    } mem_req_t;

    typedef struct packed {
        csr_addr_t address;
        logic      read_enable;
        logic      write_enable;
        csr_op_e   op;
        word_t     data;
    } csr_req_t;

    typedef struct packed {
        logic      raise;
        exc_code_e code;
        logic      mret;
        logic      interrupt_ack;
    } trap_t;

endpackage

// File: hw/exec_redirect.sv
// Kill tag counter, jump masking and trap priority selection
module exec_redirect #(
    parameter int TAG_WIDTH = 3
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [TAG_WIDTH-1:0] tag_i,
    input  logic                 taken_i,
    input  logic                 illegal_csr_i,
    input  logic                 illegal_inst_i,
    input  logic                 misaligned_fetch_i,
    input  exec_pkg::op_e        op_i,
    input  logic                 interrupt_pending_i,
    output logic                 killed_o,
    output logic                 jump_o,
    output exec_pkg::trap_t      trap_o
);
    import exec_pkg::*;

    logic [TAG_WIDTH-1:0] curr_tag;
    logic                 redirect;

    // Instructions from the old flow carry a stale tag
    assign killed_o = (curr_tag != tag_i);
    assign jump_o   = taken_i & ~killed_o;

    ////////////////////
    // Trap priority
    ////////////////////

    always_comb begin
        trap_o = '{raise: 1'b0, code: NO_EXC, mret: 1'b0, interrupt_ack: 1'b0};
        if (!killed_o && !reset) begin
            if (illegal_inst_i || illegal_csr_i) begin
                trap_o.raise = 1'b1;
                trap_o.code  = ILLEGAL_INSTRUCTION;
            end else if (misaligned_fetch_i) begin
                trap_o.raise = 1'b1;
                trap_o.code  = INSTRUCTION_ADDRESS_MISALIGNED;
            end else if (op_i == ECALL) begin
                trap_o.raise = 1'b1;
                trap_o.code  = ECALL_FROM_MMODE;
            end else if (op_i == EBREAK) begin
                trap_o.raise = 1'b1;
                trap_o.code  = BREAKPOINT;
            end else if (op_i == MRET) begin
                trap_o.mret = 1'b1;
            end else if (interrupt_pending_i) begin
                trap_o.interrupt_ack = 1'b1;
            end
        end
    end

    ////////////////////
    // Tag counter
    ////////////////////

    assign redirect = jump_o | trap_o.raise | trap_o.mret | trap_o.interrupt_ack;

    // Advances once per redirect, wraps freely
    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (redirect) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

endmodule

// File: hw/exec_stage.sv
// Execute stage top: unit wiring, result mux, write enable and output registers
module exec_stage #(
    parameter int TAG_WIDTH = 3
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall_i,
    input  exec_pkg::word_t       instruction_i,
    input  exec_pkg::word_t       pc_i,
    input  exec_pkg::word_t       first_operand_i,
    input  exec_pkg::word_t       second_operand_i,
    input  exec_pkg::word_t       third_operand_i,
    input  exec_pkg::op_e         op_i,
    input  logic [TAG_WIDTH-1:0]  tag_i,
    input  exec_pkg::priv_e       priv_i,
    input  logic                  illegal_inst_i,
    input  logic                  misaligned_fetch_i,
    input  exec_pkg::word_t       csr_read_data_i,
    input  logic                  interrupt_pending_i,
    output logic                  killed_o,
    output logic                  write_enable_o,
    output exec_pkg::op_e         op_o,
    output exec_pkg::word_t       result_o,
    output exec_pkg::mem_req_t    mem_o,
    output exec_pkg::csr_req_t    csr_o,
    output logic                  jump_o,
    output exec_pkg::word_t       target_o,
    output exec_pkg::trap_t       trap_o
);
    import exec_pkg::*;

    word_t      sum, link_sum;
    word_t      and_res, or_res, xor_res;
    word_t      sll_res, srl_res, sra_res;
    cmp_flags_t flags;
    logic       taken;
    logic       illegal_csr;
    word_t      result;
    logic       write_enable;

    exec_alu u_alu (
        .op_i       (op_i),
        .pc_i       (pc_i),
        .first_i    (first_operand_i),
        .second_i   (second_operand_i),
        .third_i    (third_operand_i),
        .sum_o      (sum),
        .link_sum_o (link_sum),
        .and_o      (and_res),
        .or_o       (or_res),
        .xor_o      (xor_res),
        .sll_o      (sll_res),
        .srl_o      (srl_res),
        .sra_o      (sra_res),
        .flags_o    (flags)
    );

    exec_branch u_branch (
        .op_i       (op_i),
        .flags_i    (flags),
        .sum_i      (sum),
        .link_sum_i (link_sum),
        .taken_o    (taken),
        .target_o   (target_o)
    );

    exec_lsu u_lsu (
        .op_i         (op_i),
        .sum_i        (sum),
        .store_data_i (third_operand_i),
        .mem_o        (mem_o)
    );

    exec_csr u_csr (
        .op_i          (op_i),
        .instruction_i (instruction_i),
        .first_i       (first_operand_i),
        .priv_i        (priv_i),
        .csr_o         (csr_o),
        .illegal_o     (illegal_csr)
    );

    exec_redirect #(
        .TAG_WIDTH (TAG_WIDTH)
    ) u_redirect (
        .clk                 (clk),
        .reset               (reset),
        .tag_i               (tag_i),
        .taken_i             (taken),
        .illegal_csr_i       (illegal_csr),
        .illegal_inst_i      (illegal_inst_i),
        .misaligned_fetch_i  (misaligned_fetch_i),
        .op_i                (op_i),
        .interrupt_pending_i (interrupt_pending_i),
        .killed_o            (killed_o),
        .jump_o              (jump_o),
        .trap_o              (trap_o)
    );

    ////////////////////
    // Result select
    ////////////////////

    always_comb begin
        unique case (op_i)
            CSRRW, CSRRS, CSRRC,
            CSRRWI, CSRRSI, CSRRCI: result = csr_read_data_i;
            JAL, JALR, SUB:         result = link_sum;
            SLT:                    result = {{(XLEN-1){1'b0}}, flags.less_than};
            SLTU:                   result = {{(XLEN-1){1'b0}}, flags.less_than_unsigned};
            LUI:                    result = second_operand_i;
            AND:                    result = and_res;
            OR:                     result = or_res;
            XOR:                    result = xor_res;
            SLL:                    result = sll_res;
            SRL:                    result = srl_res;
            SRA:                    result = sra_res;
            default:                result = sum;
        endcase
    end

    // Stores and branches never write the register file
    assign write_enable = (op_i inside {SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU})
                        ? 1'b0 : ~killed_o;

    ////////////////////
    // Output registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            write_enable_o <= 1'b0;
        end else if (!stall_i) begin
            write_enable_o <= write_enable;
        end
    end

    // Payload held while stalled
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            result_o <= result;
            op_o     <= op_i;
        end
    end

endmodule

// File: tb/exec_assert.sv
// Concurrent checks on load strobes, CSR enables and write enable after reset
module exec_assert (
    input logic               clk,
    input logic               reset,
    input exec_pkg::mem_req_t mem_i,
    input exec_pkg::csr_req_t csr_i,
    input logic               illegal_csr_i,
    input logic               write_enable_i
);
    timeunit 1ns;
    timeprecision 1ns;

    int unsigned fail_count = 0;

    // No byte strobes alongside a load
    load_no_strobe: assert property (@(posedge clk) disable iff (reset)
        mem_i.read_enable |-> (mem_i.strobe == '0))
        else begin
            fail_count++;
            $error("Byte strobes set during a load");
        end

    csr_blocked: assert property (@(posedge clk) disable iff (reset)
        illegal_csr_i |-> !(csr_i.read_enable || csr_i.write_enable))
        else begin
            fail_count++;
            $error("CSR enable high on an illegal access");
        end

    // First cycle out of reset
    reset_clears_we: assert property (@(posedge clk) $fell(reset) |-> !write_enable_i)
        else begin
            fail_count++;
            $error("Write enable set right after reset");
        end

endmodule

bind exec_stage exec_assert u_assert (
    .clk            (clk),
    .reset          (reset),
    .mem_i          (mem_o),
    .csr_i          (csr_o),
    .illegal_csr_i  (illegal_csr),
    .write_enable_i (write_enable_o)
);

// File: tb/exec_tb.sv
// Execute stage testbench with clock, reset, stimulus, reference model, compare process and report
module exec_tb;
    timeunit 1ns;
    timeprecision 1ns;

    import exec_pkg::*;

    localparam int TAG_WIDTH   = 3;
    localparam int CYCLE_LIMIT = 600;

    typedef struct packed {
        op_e   op;
        word_t result;
        logic  write_enable;
    } expect_t;

    logic                 clk;
    logic                 reset;
    logic                 stall_i;
    word_t                instruction_i;
    word_t                pc_i;
    word_t                first_operand_i;
    word_t                second_operand_i;
    word_t                third_operand_i;
    op_e                  op_i;
    logic [TAG_WIDTH-1:0] tag_i;
    priv_e                priv_i;
    logic                 illegal_inst_i;
    logic                 misaligned_fetch_i;
    word_t                csr_read_data_i;
    logic                 interrupt_pending_i;
    logic                 killed_o;
    logic                 write_enable_o;
    op_e                  op_o;
    word_t                result_o;
    mem_req_t             mem_o;
    csr_req_t             csr_o;
    logic                 jump_o;
    word_t                target_o;
    trap_t                trap_o;

    logic [TAG_WIDTH-1:0] model_tag;
    expect_t              expect_q[$];
    expect_t              pending;
    logic                 pending_valid;
    int                   error_count;
    int                   check_count;

    exec_stage #(
        .TAG_WIDTH (TAG_WIDTH)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    function automatic expect_t predict(input op_e op, input word_t pc, input word_t a,
                                        input word_t b, input word_t rdata, input logic stale);
        expect_t e;
        e.op = op;
        case (op)
            CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI: e.result = rdata;
            JAL, JALR: e.result = pc + 32'd4;
            SUB:       e.result = a - b;
            SLT:       e.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:      e.result = (a < b) ? 32'd1 : 32'd0;
            LUI:       e.result = b;
            AND:       e.result = a & b;
            OR:        e.result = a | b;
            XOR:       e.result = a ^ b;
            SLL:       e.result = a << b[4:0];
            SRL:       e.result = a >> b[4:0];
            SRA:       e.result = $signed(a) >>> b[4:0];
            default:   e.result = a + b;
        endcase
        e.write_enable = !(op inside {SB, SH, SW, BEQ, BNE, BLT, BLTU, BGE, BGEU}) && !stale;
        return e;
    endfunction

    function automatic logic branch_taken(input op_e op, input word_t a, input word_t b);
        case (op)
            BEQ:       return a == b;
            BNE:       return a != b;
            BLT:       return $signed(a) < $signed(b);
            BLTU:      return a < b;
            BGE:       return $signed(a) >= $signed(b);
            BGEU:      return a >= b;
            JAL, JALR: return 1'b1;
            default:   return 1'b0;
        endcase
    endfunction

    // Fixed priority and no trap at all for a stale instruction
    function automatic trap_t expected_trap(input logic illegal, input logic misaligned,
                                            input op_e op, input logic irq, input logic stale);
        trap_t t;
        t = '{raise: 1'b0, code: NO_EXC, mret: 1'b0, interrupt_ack: 1'b0};
        if (!stale) begin
            if (illegal) begin
                t.raise = 1'b1;
                t.code  = ILLEGAL_INSTRUCTION;
            end else if (misaligned) begin
                t.raise = 1'b1;
                t.code  = INSTRUCTION_ADDRESS_MISALIGNED;
            end else if (op == ECALL) begin
                t.raise = 1'b1;
                t.code  = ECALL_FROM_MMODE;
            end else if (op == EBREAK) begin
                t.raise = 1'b1;
                t.code  = BREAKPOINT;
            end else if (op == MRET) begin
                t.mret = 1'b1;
            end else if (irq) begin
                t.interrupt_ack = 1'b1;
            end
        end
        return t;
    endfunction

    function automatic strobe_t store_strobe(input op_e op, input logic [1:0] off);
        case (op)
            SB:      return strobe_t'(4'b0001 << off);
            SH:      return off[1] ? 4'b1100 : 4'b0011;
            SW:      return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic word_t store_data(input op_e op, input word_t d);
        case (op)
            SB:      return {4{d[7:0]}};
            SH:      return {2{d[15:0]}};
            default: return d;
        endcase
    endfunction

    ////////////////////
    // Stimulus and compare
    ////////////////////

    // One instruction per cycle and no expected output for a stalled one
    task automatic issue(input op_e op, input word_t a, input word_t b, input word_t c,
                         input logic stale, input logic hold);
        @(posedge clk);
        #10;
        stall_i             = hold;
        op_i                = op;
        pc_i                = $urandom & ~32'd3;
        first_operand_i     = a;
        second_operand_i    = b;
        third_operand_i     = c;
        csr_read_data_i     = $urandom;
        instruction_i       = '0;
        priv_i              = MACHINE;
        illegal_inst_i      = 1'b0;
        misaligned_fetch_i  = 1'b0;
        interrupt_pending_i = 1'b0;
        tag_i               = stale ? model_tag - 1'b1 : model_tag;
        if (!hold) begin
            expect_q.push_back(predict(op, pc_i, a, b, csr_read_data_i, stale));
        end
    endtask

    // Tag follows every redirect seen at the outputs
    always @(posedge clk) begin
        if (reset) begin
            model_tag <= '0;
        end else if (jump_o || trap_o.raise || trap_o.mret || trap_o.interrupt_ack) begin
            model_tag <= model_tag + 1'b1;
        end
    end

    always @(posedge clk) begin
        if (expect_q.size() > 0) begin
            pending       <= expect_q.pop_front();
            pending_valid <= 1'b1;
        end else begin
            pending_valid <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (pending_valid) begin
            check("op_o", op_o, pending.op);
            check("result_o", result_o, pending.result);
            check("write_enable_o", write_enable_o, pending.write_enable);
        end
    end

    ////////////////////
    // Tests
    ////////////////////

    task automatic random_alu();
        op_e   ops[13];
        word_t a;
        word_t b;
        ops = '{ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, LUI, JAL, JALR};
        repeat (80) begin
            a = $urandom;
            b = ($urandom_range(3) == 0) ? a : $urandom;
            issue(ops[$urandom_range(12)], a, b, $urandom, 1'b0, 1'b0);
        end
    endtask

    task automatic branch_decisions();
        op_e   ops[8];
        op_e   op;
        word_t a;
        word_t b;
        word_t c;
        word_t target;
        ops = '{BEQ, BNE, BLT, BLTU, BGE, BGEU, JAL, JALR};
        repeat (60) begin
            op = ops[$urandom_range(7)];
            a  = $urandom;
            b  = ($urandom_range(2) == 0) ? a : $urandom;
            c  = $urandom & ~32'd1;
            issue(op, a, b, c, 1'b0, 1'b0);
            #40;
            case (op)
                JAL:     target = a + b;
                JALR:    target = (a + b) & ~32'd1;
                default: target = pc_i + c;
            endcase
            check("jump_o", jump_o, branch_taken(op, a, b));
            check("target_o", target_o, target);
        end
    endtask

    task automatic stale_tag_kill();
        word_t a;
        a = $urandom;
        issue(BEQ, a, a, 32'h40, 1'b0, 1'b0);
        #40;
        check("jump_o", jump_o, 1'b1);
        // Previous flow is dropped after the redirect
        issue(ADD, a, 32'd5, '0, 1'b1, 1'b0);
        #40;
        check("killed_o", killed_o, 1'b1);
        issue(JAL, a, a, '0, 1'b1, 1'b0);
        #40;
        check("killed_o", killed_o, 1'b1);
        check("jump_o", jump_o, 1'b0);
        issue(ADD, a, 32'd5, '0, 1'b0, 1'b0);
        #40;
        check("killed_o", killed_o, 1'b0);
    endtask

    task automatic load_store_requests();
        op_e   ops[8];
        word_t a;
        word_t b;
        word_t d;
        ops = '{LB, LBU, LH, LHU, LW, SB, SH, SW};
        foreach (ops[i]) begin
            repeat (4) begin
                a = $urandom;
                b = $urandom_range(3);
                d = $urandom;
                issue(ops[i], a, b, d, 1'b0, 1'b0);
                #40;
                check("mem_o.read_enable", mem_o.read_enable, i < 5);
                check("mem_o.address", mem_o.address, (a + b) & ~32'd3);
                check("mem_o.strobe", mem_o.strobe, store_strobe(ops[i], a[1:0] + b[1:0]));
                if (i >= 5) begin
                    check("mem_o.write_data", mem_o.write_data, store_data(ops[i], d));
                end
            end
        end
    endtask

    task automatic csr_access(input op_e op, input csr_addr_t addr, input logic [4:0] rs1,
                              input logic [4:0] rd, input priv_e priv, input logic illegal);
        word_t   a;
        logic    read_exp;
        logic    write_exp;
        csr_op_e op_exp;
        a = $urandom;
        issue(op, a, $urandom, $urandom, 1'b0, 1'b0);
        instruction_i = {addr, rs1, 3'b001, rd, 7'b1110011};
        priv_i        = priv;
        #40;
        read_exp  = (op inside {CSRRW, CSRRWI}) ? (rd != '0) : 1'b1;
        write_exp = (op inside {CSRRW, CSRRWI}) ? 1'b1 : (rs1 != '0);
        op_exp    = (op inside {CSRRW, CSRRWI}) ? WRITE
                  : (op inside {CSRRS, CSRRSI}) ? SET : CLEAR;
        check("csr_o.read_enable", csr_o.read_enable, read_exp && !illegal);
        check("csr_o.write_enable", csr_o.write_enable, write_exp && !illegal);
        check("csr_o.op", csr_o.op, op_exp);
        check("csr_o.address", csr_o.address, addr);
        check("csr_o.data", csr_o.data, (op inside {CSRRW, CSRRS, CSRRC}) ? a : word_t'(rs1));
        check("trap_o", trap_o, expected_trap(illegal, 1'b0, op, 1'b0, 1'b0));
    endtask

    task automatic trap_priority();
        op_e ops[4];
        op_e op;
        int  i;
        ops = '{NOP, ECALL, EBREAK, MRET};
        for (i = 0; i < 64; i++) begin
            op = ops[i[3:2]];
            issue(op, $urandom, $urandom, $urandom, i[5], 1'b0);
            illegal_inst_i      = i[0];
            misaligned_fetch_i  = i[1];
            interrupt_pending_i = i[4];
            #40;
            check("trap_o", trap_o, expected_trap(i[0], i[1], op, i[4], i[5]));
            check("killed_o", killed_o, i[5]);
        end
    endtask

    task automatic stall_hold();
        word_t   a;
        word_t   b;
        expect_t held;
        a    = $urandom;
        b    = $urandom;
        held = predict(ADD, '0, a, b, '0, 1'b0);
        issue(ADD, a, b, '0, 1'b0, 1'b0);
        // A store under stall would clear write enable if it got through
        issue(SW, ~a, b, $urandom, 1'b0, 1'b1);
        repeat (5) begin
            @(negedge clk);
            check("result_o", result_o, held.result);
            check("write_enable_o", write_enable_o, held.write_enable);
        end
        issue(XOR, a, b, '0, 1'b0, 1'b0);
    endtask

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'hf44c_5e8d));
        error_count         = 0;
        check_count         = 0;
        pending_valid       = 1'b0;
        reset               = 1'b1;
        stall_i             = 1'b0;
        instruction_i       = '0;
        pc_i                = '0;
        first_operand_i     = '0;
        second_operand_i    = '0;
        third_operand_i     = '0;
        op_i                = NOP;
        tag_i               = '0;
        priv_i              = MACHINE;
        illegal_inst_i      = 1'b0;
        misaligned_fetch_i  = 1'b0;
        csr_read_data_i     = '0;
        interrupt_pending_i = 1'b1;
        repeat (4) @(posedge clk);
        #10;
        check("trap_o in reset", trap_o, expected_trap(1'b0, 1'b0, NOP, 1'b0, 1'b0));
        reset               = 1'b0;
        interrupt_pending_i = 1'b0;
        check("write_enable_o after reset", write_enable_o, 1'b0);

        random_alu();
        branch_decisions();
        stale_tag_kill();
        load_store_requests();
        csr_access(CSRRW, 12'h340, 5'd3, 5'd5, MACHINE, 1'b0);
        csr_access(CSRRW, 12'h340, 5'd3, 5'd0, MACHINE, 1'b0);
        csr_access(CSRRS, 12'h305, 5'd0, 5'd1, MACHINE, 1'b0);
        csr_access(CSRRC, 12'h300, 5'd4, 5'd2, MACHINE, 1'b0);
        csr_access(CSRRSI, 12'h344, 5'd9, 5'd6, MACHINE, 1'b0);
        csr_access(CSRRCI, 12'h100, 5'd7, 5'd6, SUPERVISOR, 1'b0);
        csr_access(CSRRWI, 12'h001, 5'd2, 5'd1, USER, 1'b0);
        csr_access(CSRRS, 12'hC00, 5'd0, 5'd3, USER, 1'b0);
        // Read-only write, then two accesses above the current level
        csr_access(CSRRW, 12'hC00, 5'd3, 5'd3, MACHINE, 1'b1);
        csr_access(CSRRS, 12'h300, 5'd0, 5'd3, USER, 1'b1);
        csr_access(CSRRC, 12'h100, 5'd1, 5'd3, USER, 1'b1);
        trap_priority();
        stall_hold();

        while (expect_q.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        #1;
        $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, dut.u_assert.fail_count);
        if (error_count == 0 && dut.u_assert.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
